// ==== hw/xb_dram_pkg.sv ====
package xb_dram_pkg;

  // ******************************************************************
  // Sizes of the host message channel and the line memory
  // ******************************************************************
  localparam int WORD_BITS      = 32;
  localparam int WORDS_PER_LINE = 8;
  localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
  localparam int LINE_COUNT     = 16;
  localparam int LINE_ADDR_BITS = 4;
  localparam int WORD_SEL_BITS  = 3;

  localparam int FIFO_DEPTH       = 16;
  localparam int READ_LATENCY     = 3;
  localparam int HEARTBEAT_CYCLES = 64;

  typedef logic [WORD_BITS-1:0]      msg_word_t;
  typedef logic [LINE_BITS-1:0]      mem_line_t;
  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

  // Host closes its coefficient stream with this word
  localparam msg_word_t TERMINATOR = '1;

  typedef enum logic {
    MEM_WRITE,
    MEM_READ
  } mem_cmd_t;

  // Application phases, gather first, then replay
  typedef enum logic [2:0] {
    GATHER, WRITE_LINE, READ_REQ, READ_WAIT, SEND_LINE, SEND_TERM, DONE
  } app_state_t;

endpackage

// ==== hw/msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  xb_dram_pkg::msg_word_t in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output xb_dram_pkg::msg_word_t out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  xb_dram_pkg::msg_word_t buf_mem [xb_dram_pkg::FIFO_DEPTH];

  logic [$clog2(xb_dram_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(xb_dram_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(xb_dram_pkg::FIFO_DEPTH):0]   count;
  logic push;
  logic pop;

  assign in_ready  = (count != xb_dram_pkg::FIFO_DEPTH);
  assign out_valid = (count != '0);
  // Show-ahead, head word always on the output
  assign out_data  = buf_mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/host_channels.sv ====
`timescale 1ns/1ps

module host_channels (
  input  logic                   clk,
  input  logic                   rst,
  // Host write channel
  input  xb_dram_pkg::msg_word_t wr_data,
  input  logic                   wr_valid,
  output logic                   wr_ready,
  input  logic                   wr_open,
  // Messages towards the application
  output xb_dram_pkg::msg_word_t msg_data,
  output logic                   msg_valid,
  input  logic                   msg_ready,
  output logic                   loop_ready,
  // Replies from the application
  input  xb_dram_pkg::msg_word_t reply_data,
  input  logic                   reply_valid,
  output logic                   reply_ready,
  output logic                   reply_drop,
  // Host read channel
  output xb_dram_pkg::msg_word_t rd_data,
  output logic                   rd_valid,
  input  logic                   rd_ready,
  input  logic                   rd_open,
  // Loopback channel
  output xb_dram_pkg::msg_word_t loop_data,
  output logic                   loop_valid,
  input  logic                   loop_out_ready,
  // End of file
  input  logic                   app_done,
  output logic                   rd_eof,
  output logic                   loop_eof
);

  logic rd_fifo_in_ready;

  // ******************************************************************
  // Host to application
  // ******************************************************************
  msg_fifo u_wr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (wr_data),
    .in_valid  (wr_valid),
    .in_ready  (wr_ready),
    .out_data  (msg_data),
    .out_valid (msg_valid),
    .out_ready (msg_ready)
  );

  // Copy of every word the application takes
  msg_fifo u_loop_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (msg_data),
    .in_valid  (msg_valid && msg_ready),
    .in_ready  (loop_ready),
    .out_data  (loop_data),
    .out_valid (loop_valid),
    .out_ready (loop_out_ready)
  );

  // ******************************************************************
  // Application to host
  // ******************************************************************
  // With the read channel closed, replies are swallowed and flagged
  assign reply_ready = rd_fifo_in_ready || !rd_open;
  assign reply_drop  = reply_valid && !rd_open;

  msg_fifo u_rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (reply_data),
    .in_valid  (reply_valid && rd_open),
    .in_ready  (rd_fifo_in_ready),
    .out_data  (rd_data),
    .out_valid (rd_valid),
    .out_ready (rd_ready)
  );

  assign rd_eof   = app_done && !rd_valid;
  assign loop_eof = !wr_open && !loop_valid;

endmodule

// ==== hw/line_store.sv ====
`timescale 1ns/1ps

module line_store (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_valid,
  output logic                    mem_ready,
  input  xb_dram_pkg::mem_cmd_t   mem_cmd,
  input  xb_dram_pkg::line_addr_t mem_addr,
  input  xb_dram_pkg::mem_line_t  mem_wdata,
  output logic                    rd_line_valid,
  output xb_dram_pkg::mem_line_t  rd_line,
  output logic                    init_done
);

  xb_dram_pkg::mem_line_t mem [xb_dram_pkg::LINE_COUNT];

  xb_dram_pkg::line_addr_t init_addr;
  logic sweep_we;
  logic wr_fire;
  logic rd_fire;

  logic [xb_dram_pkg::READ_LATENCY-1:0] vld_pipe;
  xb_dram_pkg::mem_line_t data_pipe [xb_dram_pkg::READ_LATENCY];

  // ******************************************************************
  // Clear sweep, one line per cycle after reset
  // ******************************************************************
  always_ff @(posedge clk) begin
    if (!rst) begin
      init_addr <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      init_addr <= init_addr + 1'b1;
      if (init_addr == xb_dram_pkg::line_addr_t'(xb_dram_pkg::LINE_COUNT - 1)) begin
        init_done <= 1'b1;
      end
    end
  end

  assign mem_ready = init_done;
  assign sweep_we  = rst && !init_done;
  assign wr_fire   = mem_valid && mem_ready && (mem_cmd == xb_dram_pkg::MEM_WRITE);
  assign rd_fire   = mem_valid && mem_ready && (mem_cmd == xb_dram_pkg::MEM_READ);

  always_ff @(posedge clk) begin
    if (sweep_we) begin
      mem[init_addr] <= '0;
    end else if (wr_fire) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // ******************************************************************
  // Fixed latency read pipeline
  // ******************************************************************
  always_ff @(posedge clk) begin
    if (!rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[xb_dram_pkg::READ_LATENCY-2:0], rd_fire};
    end
  end

  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[mem_addr];
    for (int i = 1; i < xb_dram_pkg::READ_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Last stage is the response, no back-pressure possible
  assign rd_line_valid = vld_pipe[xb_dram_pkg::READ_LATENCY-1];
  assign rd_line       = data_pipe[xb_dram_pkg::READ_LATENCY-1];

endmodule

// ==== hw/coeff_app.sv ====
`timescale 1ns/1ps

module coeff_app (
  input  logic                    clk,
  input  logic                    rst,
  // Incoming host messages
  input  xb_dram_pkg::msg_word_t  msg_data,
  input  logic                    msg_valid,
  output logic                    msg_ready,
  input  logic                    loop_ready,
  // Replies to the host
  output xb_dram_pkg::msg_word_t  reply_data,
  output logic                    reply_valid,
  input  logic                    reply_ready,
  input  logic                    reply_drop,
  // Memory user port
  output logic                    mem_valid,
  output xb_dram_pkg::mem_cmd_t   mem_cmd,
  output xb_dram_pkg::line_addr_t mem_addr,
  output xb_dram_pkg::mem_line_t  mem_wdata,
  input  logic                    mem_ready,
  input  logic                    rd_line_valid,
  input  xb_dram_pkg::mem_line_t  rd_line,
  // Status
  output logic                    app_done,
  output logic                    error,
  output logic                    heartbeat
);

  xb_dram_pkg::app_state_t state;
  xb_dram_pkg::mem_line_t  line_buf;

  logic [xb_dram_pkg::WORD_SEL_BITS-1:0]  word_cnt;
  logic [xb_dram_pkg::LINE_ADDR_BITS:0]   line_cnt;
  logic [xb_dram_pkg::LINE_ADDR_BITS:0]   rd_idx;
  logic [$clog2(xb_dram_pkg::HEARTBEAT_CYCLES)-1:0] hb_cnt;
  logic saw_term;
  logic msg_fire;
  logic is_term;
  logic last_word;

  // Only take a word when its loopback copy has room
  assign msg_ready = (state == xb_dram_pkg::GATHER) && loop_ready;
  assign msg_fire  = msg_valid && msg_ready;
  assign is_term   = (msg_data == xb_dram_pkg::TERMINATOR);
  assign last_word = (word_cnt == xb_dram_pkg::WORDS_PER_LINE - 1);

  assign mem_valid = (state == xb_dram_pkg::WRITE_LINE) ||
                     ((state == xb_dram_pkg::READ_REQ) && (rd_idx != line_cnt));
  assign mem_cmd   = (state == xb_dram_pkg::WRITE_LINE) ? xb_dram_pkg::MEM_WRITE :
                                                          xb_dram_pkg::MEM_READ;
  assign mem_addr  = (state == xb_dram_pkg::WRITE_LINE) ?
                     line_cnt[xb_dram_pkg::LINE_ADDR_BITS-1:0] :
                     rd_idx[xb_dram_pkg::LINE_ADDR_BITS-1:0];
  assign mem_wdata = line_buf;

  assign reply_valid = (state == xb_dram_pkg::SEND_LINE) || (state == xb_dram_pkg::SEND_TERM);
  assign reply_data  = (state == xb_dram_pkg::SEND_TERM) ? xb_dram_pkg::TERMINATOR :
                       line_buf[word_cnt*xb_dram_pkg::WORD_BITS +: xb_dram_pkg::WORD_BITS];
  assign app_done    = (state == xb_dram_pkg::DONE);

  // ******************************************************************
  // Line buffer, filled by messages or by a read response
  // ******************************************************************
  always_ff @(posedge clk) begin
    if ((state == xb_dram_pkg::READ_WAIT) && rd_line_valid) begin
      line_buf <= rd_line;
    end else if (msg_fire) begin
      if (is_term) begin
        // Pad the tail of a partial line
        for (int i = 0; i < xb_dram_pkg::WORDS_PER_LINE; i++) begin
          if (i >= word_cnt) begin
            line_buf[i*xb_dram_pkg::WORD_BITS +: xb_dram_pkg::WORD_BITS] <= '0;
          end
        end
      end else begin
        line_buf[word_cnt*xb_dram_pkg::WORD_BITS +: xb_dram_pkg::WORD_BITS] <= msg_data;
      end
    end
  end

  // ******************************************************************
  // Main FSM
  // ******************************************************************
  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= xb_dram_pkg::GATHER;
      word_cnt <= '0;
      line_cnt <= '0;
      rd_idx   <= '0;
      saw_term <= 1'b0;
    end else begin
      case (state)
        xb_dram_pkg::GATHER: begin
          if (msg_fire && is_term) begin
            saw_term <= 1'b1;
            state    <= (word_cnt != '0) ? xb_dram_pkg::WRITE_LINE : xb_dram_pkg::READ_REQ;
          end else if (msg_fire) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              state <= xb_dram_pkg::WRITE_LINE;
            end
          end
        end
        xb_dram_pkg::WRITE_LINE: begin
          if (mem_ready) begin
            line_cnt <= line_cnt + 1'b1;
            word_cnt <= '0;
            state    <= saw_term ? xb_dram_pkg::READ_REQ : xb_dram_pkg::GATHER;
          end
        end
        xb_dram_pkg::READ_REQ: begin
          if (rd_idx == line_cnt) begin
            state <= xb_dram_pkg::SEND_TERM;
          end else if (mem_ready) begin
            state <= xb_dram_pkg::READ_WAIT;
          end
        end
        xb_dram_pkg::READ_WAIT: begin
          if (rd_line_valid) begin
            word_cnt <= '0;
            state    <= xb_dram_pkg::SEND_LINE;
          end
        end
        xb_dram_pkg::SEND_LINE: begin
          if (reply_ready) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              rd_idx <= rd_idx + 1'b1;
              state  <= xb_dram_pkg::READ_REQ;
            end
          end
        end
        xb_dram_pkg::SEND_TERM: begin
          if (reply_ready) begin
            state <= xb_dram_pkg::DONE;
          end
        end
        default: state <= xb_dram_pkg::DONE;
      endcase
    end
  end

  // Sticky drop flag and heartbeat
  always_ff @(posedge clk) begin
    if (!rst) begin
      error     <= 1'b0;
      hb_cnt    <= '0;
      heartbeat <= 1'b0;
    end else begin
      if (reply_drop) begin
        error <= 1'b1;
      end
      if (hb_cnt == xb_dram_pkg::HEARTBEAT_CYCLES - 1) begin
        hb_cnt    <= '0;
        heartbeat <= ~heartbeat;
      end else begin
        hb_cnt <= hb_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/xb_dram_bridge.sv ====
`timescale 1ns/1ps

module xb_dram_bridge (
  input  logic                   clk,
  input  logic                   rst,
  // Host write channel
  input  xb_dram_pkg::msg_word_t wr_data,
  input  logic                   wr_valid,
  output logic                   wr_ready,
  input  logic                   wr_open,
  // Host read channel
  output xb_dram_pkg::msg_word_t rd_data,
  output logic                   rd_valid,
  input  logic                   rd_ready,
  input  logic                   rd_open,
  // Loopback channel
  output xb_dram_pkg::msg_word_t loop_data,
  output logic                   loop_valid,
  input  logic                   loop_out_ready,
  // Completion and status
  output logic                   app_done,
  output logic                   rd_eof,
  output logic                   loop_eof,
  output logic                   error,
  output logic                   heartbeat,
  output logic                   init_done,
  output logic                   app_rdy
);

  xb_dram_pkg::msg_word_t  msg_data;
  xb_dram_pkg::msg_word_t  reply_data;
  xb_dram_pkg::mem_cmd_t   mem_cmd;
  xb_dram_pkg::line_addr_t mem_addr;
  xb_dram_pkg::mem_line_t  mem_wdata;
  xb_dram_pkg::mem_line_t  rd_line;
  logic msg_valid, msg_ready, loop_ready;
  logic reply_valid, reply_ready, reply_drop;
  logic mem_valid, mem_ready, rd_line_valid;

  // Memory accepts requests once its clear sweep ends
  assign app_rdy = init_done;

  host_channels u_channels (
    .clk (clk), .rst (rst),
    .wr_data (wr_data), .wr_valid (wr_valid), .wr_ready (wr_ready), .wr_open (wr_open),
    .msg_data (msg_data), .msg_valid (msg_valid), .msg_ready (msg_ready),
    .loop_ready (loop_ready),
    .reply_data (reply_data), .reply_valid (reply_valid), .reply_ready (reply_ready),
    .reply_drop (reply_drop),
    .rd_data (rd_data), .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_open (rd_open),
    .loop_data (loop_data), .loop_valid (loop_valid), .loop_out_ready (loop_out_ready),
    .app_done (app_done), .rd_eof (rd_eof), .loop_eof (loop_eof)
  );

  coeff_app u_app (
    .clk (clk), .rst (rst),
    .msg_data (msg_data), .msg_valid (msg_valid), .msg_ready (msg_ready),
    .loop_ready (loop_ready),
    .reply_data (reply_data), .reply_valid (reply_valid), .reply_ready (reply_ready),
    .reply_drop (reply_drop),
    .mem_valid (mem_valid), .mem_cmd (mem_cmd), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_ready (mem_ready),
    .rd_line_valid (rd_line_valid), .rd_line (rd_line),
    .app_done (app_done), .error (error), .heartbeat (heartbeat)
  );

  line_store u_store (
    .clk (clk), .rst (rst),
    .mem_valid (mem_valid), .mem_ready (mem_ready), .mem_cmd (mem_cmd),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata),
    .rd_line_valid (rd_line_valid), .rd_line (rd_line), .init_done (init_done)
  );

endmodule

// ==== verification/xb_dram_bridge_assertions.sv ====
`timescale 1ns/1ps

module xb_dram_bridge_assertions (
  input logic                                clk,
  input logic                                rst,
  input logic                                reply_valid,
  input logic                                reply_ready,
  input xb_dram_pkg::msg_word_t              reply_data,
  input logic                                mem_valid,
  input logic                                mem_ready,
  input xb_dram_pkg::mem_cmd_t               mem_cmd,
  input xb_dram_pkg::line_addr_t             mem_addr,
  input xb_dram_pkg::mem_line_t              mem_wdata,
  input logic                                rd_line_valid,
  input logic [xb_dram_pkg::LINE_ADDR_BITS:0] line_cnt
);

  logic       rd_issue;
  logic [2:0] reads_pending;

  assign rd_issue = mem_valid && mem_ready && (mem_cmd == xb_dram_pkg::MEM_READ);

  always_ff @(posedge clk) begin
    if (!rst) begin
      reads_pending <= '0;
    end else begin
      reads_pending <= reads_pending + 3'(rd_issue) - 3'(rd_line_valid);
    end
  end

  a_reply_hold: assert property (@(posedge clk) disable iff (!rst)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_data))
    else $error("Reply word dropped or changed while stalled");

  a_mem_hold: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_cmd) && $stable(mem_addr) &&
                                $stable(mem_wdata))
    else $error("Memory request dropped or changed while stalled");

  // Writing past the last line would wrap onto line zero
  a_addr_range: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && (mem_cmd == xb_dram_pkg::MEM_WRITE) |-> (line_cnt < xb_dram_pkg::LINE_COUNT))
    else $error("Memory address beyond line capacity");

  a_no_orphan_read: assert property (@(posedge clk) disable iff (!rst)
    rd_line_valid |-> reads_pending != '0)
    else $error("Read data returned with no read in flight");

endmodule

bind coeff_app xb_dram_bridge_assertions u_assertions (
  .clk (clk), .rst (rst),
  .reply_valid (reply_valid), .reply_ready (reply_ready), .reply_data (reply_data),
  .mem_valid (mem_valid), .mem_ready (mem_ready), .mem_cmd (mem_cmd),
  .mem_addr (mem_addr), .mem_wdata (mem_wdata),
  .rd_line_valid (rd_line_valid), .line_cnt (line_cnt)
);

// ==== verification/xb_dram_bridge_tb.sv ====
`timescale 1ns/1ps

module xb_dram_bridge_tb;

  localparam string STIM_FILE = "verification/bridge_stimulus.txt";

  logic                   clk;
  logic                   rst;
  xb_dram_pkg::msg_word_t wr_data;
  logic                   wr_valid, wr_ready, wr_open;
  xb_dram_pkg::msg_word_t rd_data;
  logic                   rd_valid, rd_ready, rd_open;
  xb_dram_pkg::msg_word_t loop_data;
  logic                   loop_valid, loop_out_ready;
  logic                   app_done, rd_eof, loop_eof;
  logic                   error, heartbeat, init_done, app_rdy;

  // Test records as loaded from the stimulus file
  string                  test_name [$];
  int                     test_rd_open [$];
  int                     test_stall [$];
  int                     test_first [$];
  int                     test_len [$];
  xb_dram_pkg::msg_word_t stim_words [$];

  string                  cur_name;
  bit                     collecting;
  bit                     stall_mode;
  int                     cycle_count;
  int                     cycle_limit;
  int                     up_cycles;
  int                     error_count;
  int                     test_count;
  xb_dram_pkg::msg_word_t rd_exp [$];
  xb_dram_pkg::msg_word_t rd_got [$];
  xb_dram_pkg::msg_word_t loop_exp [$];
  xb_dram_pkg::msg_word_t loop_got [$];

  xb_dram_bridge u_dut (
    .clk (clk), .rst (rst),
    .wr_data (wr_data), .wr_valid (wr_valid), .wr_ready (wr_ready), .wr_open (wr_open),
    .rd_data (rd_data), .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_open (rd_open),
    .loop_data (loop_data), .loop_valid (loop_valid), .loop_out_ready (loop_out_ready),
    .app_done (app_done), .rd_eof (rd_eof), .loop_eof (loop_eof),
    .error (error), .heartbeat (heartbeat), .init_done (init_done), .app_rdy (app_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycles overall, and cycles since reset was released
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (!rst) begin
      up_cycles <= 0;
    end else begin
      up_cycles <= up_cycles + 1;
    end
  end

  // Host side ready, with random gaps in stall mode
  always begin
    @(posedge clk);
    #1;
    if (stall_mode) begin
      rd_ready       = ($urandom % 4) != 0;
      loop_out_ready = ($urandom % 4) != 0;
    end else begin
      rd_ready       = 1'b1;
      loop_out_ready = 1'b1;
    end
  end

  task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    error_count++;
    $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, exp, act);
  endtask

  // ******************************************************************
  // Monitors, sampled on the falling edge
  // ******************************************************************
  always @(negedge clk) begin
    if (up_cycles > 0) begin
      if (init_done !== (up_cycles >= xb_dram_pkg::LINE_COUNT)) begin
        report_value("init_done", up_cycles >= xb_dram_pkg::LINE_COUNT, init_done);
      end
      if (app_rdy !== (up_cycles >= xb_dram_pkg::LINE_COUNT)) begin
        report_value("app_rdy", up_cycles >= xb_dram_pkg::LINE_COUNT, app_rdy);
      end
      if (heartbeat !== 1'((up_cycles / xb_dram_pkg::HEARTBEAT_CYCLES) % 2)) begin
        report_value("heartbeat", (up_cycles / xb_dram_pkg::HEARTBEAT_CYCLES) % 2, heartbeat);
      end
    end
    if (collecting) begin
      // Sizes before this edge's transfer are the words already taken
      if (rd_eof !== (app_done && rd_got.size() >= rd_exp.size())) begin
        report_value("rd_eof", app_done && rd_got.size() >= rd_exp.size(), rd_eof);
      end
      if (loop_eof !== (!wr_open && loop_got.size() >= loop_exp.size())) begin
        report_value("loop_eof", !wr_open && loop_got.size() >= loop_exp.size(), loop_eof);
      end
      if (!rd_open && rd_valid) begin
        error_count++;
        $display("Test %s: a word showed up on the closed read channel", cur_name);
      end
      if (rd_valid && rd_ready) begin
        rd_got.push_back(rd_data);
      end
      if (loop_valid && loop_out_ready) begin
        loop_got.push_back(loop_data);
      end
    end
  end

  task automatic load_stimulus();
    int                     fd;
    int                     code;
    int                     rd_flag;
    int                     stall_flag;
    int                     first;
    bit                     done;
    string                  tok;
    string                  rest;
    xb_dram_pkg::msg_word_t w;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      error_count++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[0] == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code  = $fscanf(fd, "%d %d", rd_flag, stall_flag);
        first = stim_words.size();
        done  = 1'b0;
        while (!done) begin
          code = $fscanf(fd, "%h", w);
          if (code != 1) begin
            $display("Stimulus record %s ends without a terminator word", tok);
            error_count++;
            done = 1'b1;
          end else begin
            stim_words.push_back(w);
            done = (w == xb_dram_pkg::TERMINATOR);
          end
        end
        test_name.push_back(tok);
        test_rd_open.push_back(rd_flag);
        test_stall.push_back(stall_flag);
        test_first.push_back(first);
        test_len.push_back(stim_words.size() - first);
        cycle_limit += 20 * (stim_words.size() - first) + 100;
      end
    end
    $fclose(fd);
    if (test_name.size() == 0) begin
      $display("No test records found in %s", STIM_FILE);
      error_count++;
    end
  endtask

  task automatic send_words(input int first, input int len);
    for (int i = 0; i < len; i++) begin
      wr_data  = stim_words[first + i];
      wr_valid = 1'b1;
      @(negedge clk);
      while (!wr_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    wr_valid = 1'b0;
  endtask

  task automatic compare_stream(input string what, input xb_dram_pkg::msg_word_t exp_q[$],
                                input xb_dram_pkg::msg_word_t got_q[$]);
    if (got_q.size() != exp_q.size()) begin
      report_value({what, " word count"}, exp_q.size(), got_q.size());
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      if (got_q[i] !== exp_q[i]) begin
        report_value($sformatf("%s word %0d", what, i), exp_q[i], got_q[i]);
      end
    end
  endtask

  // ******************************************************************
  // One test: reset, stream, drain, compare
  // ******************************************************************
  task automatic run_test(input int t);
    int first;
    int len;
    first    = test_first[t];
    len      = test_len[t];
    cur_name = test_name[t];
    test_count++;
    rd_exp.delete();
    rd_got.delete();
    loop_exp.delete();
    loop_got.delete();
    for (int i = 0; i < len; i++) begin
      loop_exp.push_back(stim_words[first + i]);
    end
    // Data words padded with zeros to whole lines, terminator last
    if (test_rd_open[t] != 0) begin
      for (int i = 0; i < len - 1; i++) begin
        rd_exp.push_back(stim_words[first + i]);
      end
      while (rd_exp.size() % xb_dram_pkg::WORDS_PER_LINE != 0) begin
        rd_exp.push_back('0);
      end
      rd_exp.push_back(xb_dram_pkg::TERMINATOR);
    end
    @(posedge clk);
    #1;
    rst        = 1'b0;
    wr_valid   = 1'b0;
    wr_open    = 1'b1;
    rd_open    = (test_rd_open[t] != 0);
    stall_mode = (test_stall[t] != 0);
    repeat (2) @(posedge clk);
    #1;
    rst        = 1'b1;
    collecting = 1'b1;
    send_words(first, len);
    while (!app_done) @(negedge clk);
    while (loop_got.size() < loop_exp.size() || rd_got.size() < rd_exp.size()) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    wr_open = 1'b0;
    repeat (2) @(negedge clk);
    collecting = 1'b0;
    compare_stream("read", rd_exp, rd_got);
    compare_stream("loopback", loop_exp, loop_got);
    if (app_done !== 1'b1) begin
      report_value("app_done", 1, app_done);
    end
    if (error !== !rd_open) begin
      report_value("error", !rd_open, error);
    end
  endtask

  initial begin
    rst            = 1'b0;
    wr_data        = '0;
    wr_valid       = 1'b0;
    wr_open        = 1'b1;
    rd_ready       = 1'b1;
    rd_open        = 1'b1;
    loop_out_ready = 1'b1;
    collecting     = 1'b0;
    stall_mode     = 1'b0;
    cycle_limit    = 0;
    error_count    = 0;
    test_count     = 0;
    void'($urandom(32219));
    load_stimulus();
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    @(posedge clk);
    while (cycle_count < cycle_limit) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verification/bridge_stimulus.txt ====
# test_name rd_open stall, then hex words closed by the ffffffff terminator
# rd_open 0 closes the host read channel, stall 1 adds random ready gaps
two_full_lines 1 0
  00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
  10000001 10000002 10000003 10000004 10000005 10000006 10000007 10000008
  ffffffff
partial_line 1 0
  a5a50000 a5a50001 a5a50002 a5a50003 a5a50004 a5a50005 a5a50006 a5a50007
  5a5a0008 5a5a0009 5a5a000a
  ffffffff
ready_stalls 1 1
  c0ef0000 c0ef0011 c0ef0022 c0ef0033 c0ef0044 c0ef0055 c0ef0066 c0ef0077
  0badf00d 1badf00d 2badf00d 3badf00d 4badf00d 5badf00d 6badf00d 7badf00d
  fffffffe 7fffffff 80000000 00000000 12345678 9abcdef0 deadbeef cafebabe
  00c0ffee 0ddba11a 0feedbac
  ffffffff
closed_read 0 0
  11111111 22222222 33333333 44444444 55555555
  ffffffff
only_terminator 1 0
  ffffffff
zero_words 1 1
  00000000 00000000 00000001 00000000 fffffffe
  ffffffff

// ==== xb_dram_bridge.f ====
hw/xb_dram_pkg.sv
hw/msg_fifo.sv
hw/host_channels.sv
hw/line_store.sv
hw/coeff_app.sv
hw/xb_dram_bridge.sv
verification/xb_dram_bridge_assertions.sv
verification/xb_dram_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module xb_dram_bridge_tb \
  -f xb_dram_bridge.f \
  -o sim_bridge

output="$(./obj_dir/sim_bridge 2>&1)" || true
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
